// ==== project.f ====
pipe_pkg.sv
reg_file.sv
fetch_stage.sv
decode_stage.sv
exec_stage.sv
mem_stage.sv
pipeline.sv
tb_pipeline.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and pass only if the pass line is printed
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timescale 1ns/1ps -j 0 --top-module tb_pipeline -f project.f \
  || exit 1
out=$(./obj_dir/Vtb_pipeline)
echo "$out"
echo "$out" | grep -qx "TEST OK" && exit 0 || exit 1

// ==== tb_pipeline.sv ====
//////////////////////////////////////////////////
// Pipeline testbench
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_pipeline
  import pipe_pkg::*;
();

  typedef struct packed {
    logic [ADDR_W-1:0]    pc;
    logic                 wr;       // Nonzero register written
    logic [REG_IDX_W-1:0] idx;
    logic [XLEN-1:0]      data;
    error_e               status;
  } commit_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [XLEN-1:0]   data;
  } store_t;

  logic                 clock;
  logic                 reset;
  logic [XLEN-1:0]      mem_rdata;
  bus_cmd_e             mem_cmd;
  logic [ADDR_W-1:0]    mem_addr;
  logic [XLEN-1:0]      mem_wdata;
  logic                 commit_valid;
  logic [ADDR_W-1:0]    commit_pc;
  logic                 commit_wr_en;
  logic [REG_IDX_W-1:0] commit_wr_idx;
  logic [XLEN-1:0]      commit_wr_data;
  error_e               error_status;

  logic [XLEN-1:0] mem   [0:1023];   // Memory behind the port
  logic [XLEN-1:0] image [0:1023];   // Code and data, copied in during reset
  commit_t         exp_commits [$];
  store_t          exp_stores  [$];
  int              seed;
  int              errors;
  int              checks;
  int              prog_len;

  pipeline u_dut (.*);

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  //////////////////////////////////////////////////
  // Memory model
  //////////////////////////////////////////////////
  always @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 1024; i++) mem[i] <= image[i];
    end else if (mem_cmd == BUS_STORE) begin
      mem[mem_addr] <= mem_wdata;   // Store lands on the edge
    end
  end

  assign mem_rdata = mem[mem_addr];   // Combinational read

  function automatic int rnd(input int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % 32'(n));
  endfunction

  function automatic logic [XLEN-1:0] encode(input logic [3:0] op, input logic [3:0] rd,
                                             input logic [3:0] ra, input logic [3:0] rb,
                                             input logic [15:0] imm);
    return {op, rd, ra, rb, imm};
  endfunction

  task automatic expect_true(input bit ok, input string msg);
    checks++;
    assert (ok) else begin
      $display("[FAIL] t=%0t %s", $time, msg);
      errors++;
    end
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $finish;
  endtask

  //////////////////////////////////////////////////
  // Program generator
  //////////////////////////////////////////////////
  task automatic gen_program(input int p);
    int          i;
    int          k;
    int          span;
    logic [3:0]  op;
    logic [3:0]  rd, ra, rb;
    logic [15:0] imm;
    prog_len = 60 + rnd(140);
    for (i = 0; i < 1024; i++) begin
      if (i < 512) image[i] = encode(OP_HALT, 4'd0, 4'd0, 4'd0, 16'd0);
      else image[i] = $random(seed);   // Data region
    end
    for (i = 0; i < prog_len - 1; i++) begin
      rd  = 4'(rnd(6));   // Only r0..r5, so hazards are frequent
      ra  = 4'(rnd(6));
      rb  = 4'(rnd(6));
      imm = 16'(rnd(65536));
      k   = rnd(16);
      if (k < 6) begin
        op = 4'(k);   // ADD..SLT
      end else if (k < 9) begin
        op = OP_ADDI;
      end else if (k < 13) begin
        op  = (k < 11) ? OP_LD : OP_ST;
        ra  = 4'd0;
        imm = 16'(512 + (rnd(2) == 0 ? rnd(16) : rnd(512)));   // Hot set or anywhere
        if (op == OP_ST) rd = 4'd0;
      end else begin
        op   = (k == 13) ? OP_BEQ : OP_BNE;
        span = (prog_len - 1 - i < 8) ? prog_len - 1 - i : 8;
        imm  = 16'(rnd(span));   // Forward, never past the last word
        rd   = 4'd0;
      end
      image[i] = encode(op, rd, ra, rb, imm);
    end
    if (p == 3) begin
      image[prog_len-1] = encode(4'(12 + rnd(4)), 4'd0, 4'd0, 4'd0, 16'd0);   // Undefined
    end
  endtask

  //////////////////////////////////////////////////
  // ISA reference model
  //////////////////////////////////////////////////
  task automatic run_model();
    logic [XLEN-1:0]   regs [0:15];
    logic [XLEN-1:0]   dmem [0:1023];
    logic [ADDR_W-1:0] pc, npc;
    logic [XLEN-1:0]   inst, a, b, imm, res;
    logic [3:0]        opv, rd, ra, rb;
    logic              wr;
    bit                done;
    int                steps;
    commit_t           c;
    store_t            s;
    for (int i = 0; i < 16; i++) regs[i] = '0;
    for (int i = 0; i < 1024; i++) dmem[i] = image[i];
    exp_commits.delete();
    exp_stores.delete();
    pc    = '0;
    done  = 1'b0;
    steps = 0;
    while (!done && steps < 1000) begin
      inst = dmem[pc];
      opv  = inst[31:28];
      rd   = inst[27:24];
      ra   = inst[23:20];
      rb   = inst[19:16];
      imm  = {{16{inst[15]}}, inst[15:0]};
      a    = regs[ra];
      b    = regs[rb];
      npc  = pc + 10'd1;
      res  = '0;
      wr   = 1'b0;
      c    = '{pc: pc, wr: 1'b0, idx: rd, data: '0, status: NO_ERROR};
      case (opv)
        OP_ADD:  begin res = a + b; wr = 1'b1; end
        OP_SUB:  begin res = a - b; wr = 1'b1; end
        OP_AND:  begin res = a & b; wr = 1'b1; end
        OP_OR:   begin res = a | b; wr = 1'b1; end
        OP_XOR:  begin res = a ^ b; wr = 1'b1; end
        OP_SLT:  begin res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0; wr = 1'b1; end
        OP_ADDI: begin res = a + imm; wr = 1'b1; end
        OP_LD:   begin res = dmem[10'(a + imm)]; wr = 1'b1; end
        OP_ST: begin
          s.addr = 10'(a + imm);
          s.data = b;
          dmem[s.addr] = b;
          exp_stores.push_back(s);
        end
        OP_BEQ:  if (a == b) npc = pc + 10'd1 + imm[9:0];
        OP_BNE:  if (a != b) npc = pc + 10'd1 + imm[9:0];
        OP_HALT: begin c.status = HALTED_ON_HALT; done = 1'b1; end
        default: begin c.status = HALTED_ON_ILLEGAL; done = 1'b1; end
      endcase
      if (wr && rd != 4'd0) begin
        regs[rd] = res;
        c.wr     = 1'b1;
        c.data   = res;
      end
      exp_commits.push_back(c);
      pc = npc;
      steps++;
    end
  endtask

  // One cycle; stores are checked where the port is stable
  task automatic step_cycle();
    store_t s;
    @(negedge clock);
    if (!reset && mem_cmd == BUS_STORE) begin
      if (exp_stores.size() == 0) begin
        expect_true(1'b0, $sformatf("unexpected store to address %0d", mem_addr));
      end else begin
        s = exp_stores.pop_front();
        expect_true(mem_addr == s.addr && mem_wdata == s.data,
                    $sformatf("store %0d <- %h, expected %0d <- %h",
                              mem_addr, mem_wdata, s.addr, s.data));
      end
    end
  endtask

  task automatic wait_commit(output bit seen);
    int n;
    seen = 1'b0;
    for (n = 0; n < 200 && !seen; n++) begin
      step_cycle();
      seen = commit_valid;
    end
  endtask

  task automatic check_idle(input string when_s);
    expect_true(!commit_valid && !commit_wr_en, $sformatf("commit active %s", when_s));
    expect_true(error_status == NO_ERROR, $sformatf("error_status set %s", when_s));
    expect_true(mem_cmd == BUS_LOAD && mem_addr == '0,
                $sformatf("port not fetching address 0 %s", when_s));
  endtask

  task automatic apply_reset();
    @(posedge clock);
    #1 reset = 1'b1;
    for (int i = 0; i < 10; i++) begin
      @(negedge clock);
      if (i > 0) check_idle("during reset");   // First edge not seen yet
      @(posedge clock);
    end
    #1 reset = 1'b0;
    @(negedge clock);
    check_idle("after reset");
  endtask

  //////////////////////////////////////////////////
  // Commit checking
  //////////////////////////////////////////////////
  task automatic run_program(input int p, input int e0);
    commit_t c;
    error_e  last;
    bit      seen;
    int      n_commits;
    int      n_stores;
    n_commits = exp_commits.size();
    n_stores  = exp_stores.size();
    last      = NO_ERROR;
    while (exp_commits.size() > 0) begin
      c = exp_commits.pop_front();
      wait_commit(seen);
      if (!seen) begin
        abort_run($sformatf("Timeout: pc %0d did not commit within 200 cycles", c.pc));
      end else begin
        expect_true(commit_pc == c.pc,
                    $sformatf("commit pc %0d, expected %0d", commit_pc, c.pc));
        expect_true(commit_wr_en == c.wr,
                    $sformatf("pc %0d commit_wr_en %0b, expected %0b",
                              c.pc, commit_wr_en, c.wr));
        if (c.wr) begin
          expect_true(commit_wr_idx == c.idx && commit_wr_data == c.data,
                      $sformatf("pc %0d wrote r%0d = %h, expected r%0d = %h",
                                c.pc, commit_wr_idx, commit_wr_data, c.idx, c.data));
        end
        expect_true(error_status == c.status,
                    $sformatf("pc %0d error_status %s, expected %s",
                              c.pc, error_status.name(), c.status.name()));
        last = c.status;
      end
    end
    // Only HALT words follow, nothing may write
    for (int i = 0; i < 20; i++) begin
      step_cycle();
      expect_true(!commit_wr_en, "register write after the program stopped");
    end
    expect_true(exp_stores.size() == 0,
                $sformatf("%0d expected stores never appeared", exp_stores.size()));
    $display("program %0d: %0d words, %0d commits, %0d stores, %s, %0d errors",
             p, prog_len, n_commits, n_stores, last.name(), errors - e0);
  endtask

  initial begin
    int e0;
    seed   = 32'h2206;
    reset  = 1'b1;
    errors = 0;
    checks = 0;
    for (int p = 0; p < 5; p++) begin
      e0 = errors;
      gen_program(p);
      run_model();
      apply_reset();
      run_program(p, e0);
    end
    $display("5 programs, %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== pipeline.sv ====
//////////////////////////////////////////////////
// Five-stage pipeline top level
//////////////////////////////////////////////////

`timescale 1ns/1ps

module pipeline
  import pipe_pkg::*;
(
  input  logic                 clock,
  input  logic                 reset,
  input  logic [XLEN-1:0]      mem_rdata,
  output bus_cmd_e             mem_cmd,
  output logic [ADDR_W-1:0]    mem_addr,
  output logic [XLEN-1:0]      mem_wdata,
  output logic                 commit_valid,
  output logic [ADDR_W-1:0]    commit_pc,
  output logic                 commit_wr_en,
  output logic [REG_IDX_W-1:0] commit_wr_idx,
  output logic [XLEN-1:0]      commit_wr_data,
  output error_e               error_status
);

  // Fetch and IF/ID
  logic [ADDR_W-1:0]    fetch_addr, if_id_pc;
  logic [XLEN-1:0]      if_id_inst;
  logic                 if_id_valid, id_stall;
  // ID/EX
  logic [ADDR_W-1:0]    id_ex_pc;
  logic [XLEN-1:0]      id_ex_rega, id_ex_regb, id_ex_imm;
  alu_func_e            id_ex_alu_func;
  logic [REG_IDX_W-1:0] id_ex_dest;
  logic                 id_ex_use_imm, id_ex_wr, id_ex_rd_mem, id_ex_wr_mem;
  logic                 id_ex_beq, id_ex_bne, id_ex_halt, id_ex_illegal, id_ex_valid;
  // EX/MEM
  logic                 ex_mem_take_branch;
  logic [ADDR_W-1:0]    ex_mem_target, ex_mem_pc;
  logic [XLEN-1:0]      ex_mem_result, ex_mem_store_data;
  logic [REG_IDX_W-1:0] ex_mem_dest;
  logic                 ex_mem_wr, ex_mem_rd_mem, ex_mem_wr_mem;
  logic                 ex_mem_halt, ex_mem_illegal, ex_mem_valid;
  // MEM stage and MEM/WB
  bus_cmd_e             dmem_cmd;
  logic [ADDR_W-1:0]    dmem_addr, wb_pc;
  logic                 mem_busy, wb_wr_en, wb_valid, wb_halt, wb_illegal;
  logic [REG_IDX_W-1:0] wb_wr_idx;
  logic [XLEN-1:0]      wb_wr_data;

  fetch_stage  u_fetch  (.*);
  decode_stage u_decode (.*);
  exec_stage   u_exec   (.*);
  mem_stage    u_mem    (.*);

  //////////////////////////////////////////////////
  // Shared memory port
  //////////////////////////////////////////////////
  assign mem_cmd  = (dmem_cmd == BUS_NONE) ? BUS_LOAD : dmem_cmd;     // Idle port fetches
  assign mem_addr = (dmem_cmd == BUS_NONE) ? fetch_addr : dmem_addr;

  // Commit from writeback
  assign commit_valid   = wb_valid;
  assign commit_pc      = wb_pc;
  assign commit_wr_en   = wb_wr_en;
  assign commit_wr_idx  = wb_wr_idx;
  assign commit_wr_data = wb_wr_data;

  assign error_status = wb_illegal ? HALTED_ON_ILLEGAL :
                        wb_halt    ? HALTED_ON_HALT    :
                                     NO_ERROR;

endmodule

// ==== mem_stage.sv ====
//////////////////////////////////////////////////
// Memory access and MEM/WB register
//////////////////////////////////////////////////

`timescale 1ns/1ps

module mem_stage
  import pipe_pkg::*;
(
  input  logic                 clock,
  input  logic                 reset,
  input  logic [XLEN-1:0]      ex_mem_result,
  input  logic [XLEN-1:0]      ex_mem_store_data,
  input  logic [REG_IDX_W-1:0] ex_mem_dest,
  input  logic                 ex_mem_wr,
  input  logic                 ex_mem_rd_mem,
  input  logic                 ex_mem_wr_mem,
  input  logic                 ex_mem_halt,
  input  logic                 ex_mem_illegal,
  input  logic                 ex_mem_valid,
  input  logic [ADDR_W-1:0]    ex_mem_pc,
  input  logic [XLEN-1:0]      mem_rdata,
  output bus_cmd_e             dmem_cmd,
  output logic [ADDR_W-1:0]    dmem_addr,
  output logic [XLEN-1:0]      mem_wdata,
  output logic                 mem_busy,
  output logic                 wb_wr_en,
  output logic [REG_IDX_W-1:0] wb_wr_idx,
  output logic [XLEN-1:0]      wb_wr_data,
  output logic [ADDR_W-1:0]    wb_pc,
  output logic                 wb_valid,
  output logic                 wb_halt,
  output logic                 wb_illegal
);

  always_comb begin
    dmem_cmd = BUS_NONE;
    if (ex_mem_valid && ex_mem_rd_mem)      dmem_cmd = BUS_LOAD;
    else if (ex_mem_valid && ex_mem_wr_mem) dmem_cmd = BUS_STORE;
  end

  assign dmem_addr = ex_mem_result[ADDR_W-1:0];   // Word address from ALU
  assign mem_wdata = ex_mem_store_data;
  assign mem_busy  = dmem_cmd != BUS_NONE;        // Fetch loses the port

  //////////////////////////////////////////////////
  // MEM/WB register
  //////////////////////////////////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      wb_valid   <= 1'b0;
      wb_wr_en   <= 1'b0;
      wb_halt    <= 1'b0;
      wb_illegal <= 1'b0;
    end else begin
      wb_valid   <= ex_mem_valid;
      wb_wr_en   <= ex_mem_valid && ex_mem_wr && ex_mem_dest != '0;
      wb_halt    <= ex_mem_valid && ex_mem_halt;
      wb_illegal <= ex_mem_valid && ex_mem_illegal;
    end
  end

  always_ff @(posedge clock) begin
    wb_wr_idx  <= ex_mem_dest;
    wb_wr_data <= ex_mem_rd_mem ? mem_rdata : ex_mem_result;   // Load data or ALU
    wb_pc      <= ex_mem_pc;
  end

endmodule

// ==== exec_stage.sv ====
//////////////////////////////////////////////////
// Execute and EX/MEM register
//////////////////////////////////////////////////

`timescale 1ns/1ps

module exec_stage
  import pipe_pkg::*;
(
  input  logic                 clock,
  input  logic                 reset,
  input  logic [ADDR_W-1:0]    id_ex_pc,
  input  logic [XLEN-1:0]      id_ex_rega,
  input  logic [XLEN-1:0]      id_ex_regb,
  input  logic [XLEN-1:0]      id_ex_imm,
  input  alu_func_e            id_ex_alu_func,
  input  logic                 id_ex_use_imm,
  input  logic [REG_IDX_W-1:0] id_ex_dest,
  input  logic                 id_ex_wr,
  input  logic                 id_ex_rd_mem,
  input  logic                 id_ex_wr_mem,
  input  logic                 id_ex_beq,
  input  logic                 id_ex_bne,
  input  logic                 id_ex_halt,
  input  logic                 id_ex_illegal,
  input  logic                 id_ex_valid,
  output logic                 ex_mem_take_branch,
  output logic [ADDR_W-1:0]    ex_mem_target,
  output logic [XLEN-1:0]      ex_mem_result,
  output logic [XLEN-1:0]      ex_mem_store_data,
  output logic [REG_IDX_W-1:0] ex_mem_dest,
  output logic                 ex_mem_wr,
  output logic                 ex_mem_rd_mem,
  output logic                 ex_mem_wr_mem,
  output logic                 ex_mem_halt,
  output logic                 ex_mem_illegal,
  output logic                 ex_mem_valid,
  output logic [ADDR_W-1:0]    ex_mem_pc
);

  logic [XLEN-1:0] opb, alu_out;
  logic            equal, take_branch;

  assign opb = id_ex_use_imm ? id_ex_imm : id_ex_regb;

  always_comb begin
    case (id_ex_alu_func)
      ALU_SUB: alu_out = id_ex_rega - opb;
      ALU_AND: alu_out = id_ex_rega & opb;
      ALU_OR:  alu_out = id_ex_rega | opb;
      ALU_XOR: alu_out = id_ex_rega ^ opb;
      ALU_SLT: alu_out = {{(XLEN-1){1'b0}}, $signed(id_ex_rega) < $signed(opb)};
      default: alu_out = id_ex_rega + opb;   // ADD, ADDI and LD/ST address
    endcase
  end

  // Branch flags are already zero in bubbles
  assign equal       = id_ex_rega == id_ex_regb;
  assign take_branch = (id_ex_beq && equal) || (id_ex_bne && !equal);

  //////////////////////////////////////////////////
  // EX/MEM register
  //////////////////////////////////////////////////
  always_ff @(posedge clock) begin
    if (reset || ex_mem_take_branch) begin   // Drop the wrong-path instruction
      ex_mem_take_branch <= 1'b0;
      ex_mem_wr          <= 1'b0;
      ex_mem_rd_mem      <= 1'b0;
      ex_mem_wr_mem      <= 1'b0;
      ex_mem_halt        <= 1'b0;
      ex_mem_illegal     <= 1'b0;
      ex_mem_valid       <= 1'b0;
    end else begin
      ex_mem_take_branch <= take_branch;
      ex_mem_wr          <= id_ex_wr;
      ex_mem_rd_mem      <= id_ex_rd_mem;
      ex_mem_wr_mem      <= id_ex_wr_mem;
      ex_mem_halt        <= id_ex_halt;
      ex_mem_illegal     <= id_ex_illegal;
      ex_mem_valid       <= id_ex_valid;
    end
  end

  always_ff @(posedge clock) begin
    ex_mem_target     <= id_ex_pc + ADDR_W'(1) + id_ex_imm[ADDR_W-1:0];
    ex_mem_result     <= alu_out;
    ex_mem_store_data <= id_ex_regb;
    ex_mem_dest       <= id_ex_dest;
    ex_mem_pc         <= id_ex_pc;
  end

  a_one_mem_op: assert property (@(posedge clock) disable iff (reset)
    !(ex_mem_rd_mem && ex_mem_wr_mem));

endmodule

// ==== decode_stage.sv ====
//////////////////////////////////////////////////
// Decode, hazard stall and ID/EX register
//////////////////////////////////////////////////

`timescale 1ns/1ps

module decode_stage
  import pipe_pkg::*;
(
  input  logic                 clock,
  input  logic                 reset,
  input  logic [ADDR_W-1:0]    if_id_pc,
  input  logic [XLEN-1:0]      if_id_inst,
  input  logic                 if_id_valid,
  input  logic                 ex_mem_take_branch,
  input  logic [REG_IDX_W-1:0] ex_mem_dest,
  input  logic                 ex_mem_wr,
  input  logic                 wb_wr_en,
  input  logic [REG_IDX_W-1:0] wb_wr_idx,
  input  logic [XLEN-1:0]      wb_wr_data,
  output logic                 id_stall,
  output logic [ADDR_W-1:0]    id_ex_pc,
  output logic [XLEN-1:0]      id_ex_rega,
  output logic [XLEN-1:0]      id_ex_regb,
  output logic [XLEN-1:0]      id_ex_imm,
  output alu_func_e            id_ex_alu_func,
  output logic                 id_ex_use_imm,
  output logic [REG_IDX_W-1:0] id_ex_dest,
  output logic                 id_ex_wr,
  output logic                 id_ex_rd_mem,
  output logic                 id_ex_wr_mem,
  output logic                 id_ex_beq,
  output logic                 id_ex_bne,
  output logic                 id_ex_halt,
  output logic                 id_ex_illegal,
  output logic                 id_ex_valid
);

  opcode_e              op;
  logic [REG_IDX_W-1:0] rd, ra, rb;
  logic [XLEN-1:0]      rega, regb, imm;
  alu_func_e            dec_alu_func;
  logic                 use_ra, use_rb;
  logic                 dec_use_imm, dec_wr, dec_rd_mem, dec_wr_mem;
  logic                 dec_beq, dec_bne, dec_halt, dec_illegal;

  assign op  = opcode_e'(if_id_inst[31:28]);
  assign rd  = if_id_inst[27:24];
  assign ra  = if_id_inst[23:20];
  assign rb  = if_id_inst[19:16];
  assign imm = {{(XLEN-IMM_W){if_id_inst[IMM_W-1]}}, if_id_inst[IMM_W-1:0]};  // Sign extend

  reg_file u_reg_file (
    .clock     (clock),
    .reset     (reset),
    .rd_idx_a  (ra),
    .rd_idx_b  (rb),
    .rd_data_a (rega),
    .rd_data_b (regb),
    .wr_en     (wb_wr_en),
    .wr_idx    (wb_wr_idx),
    .wr_data   (wb_wr_data)
  );

  always_comb begin
    dec_alu_func = ALU_ADD;   // Also the address adder for LD/ST
    dec_use_imm  = 1'b0;
    dec_wr       = 1'b0;
    dec_rd_mem   = 1'b0;
    dec_wr_mem   = 1'b0;
    dec_beq      = 1'b0;
    dec_bne      = 1'b0;
    dec_halt     = 1'b0;
    dec_illegal  = 1'b0;
    use_ra       = 1'b1;
    use_rb       = 1'b0;
    case (op)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT: begin
        dec_wr = 1'b1;
        use_rb = 1'b1;
        case (op)
          OP_SUB:  dec_alu_func = ALU_SUB;
          OP_AND:  dec_alu_func = ALU_AND;
          OP_OR:   dec_alu_func = ALU_OR;
          OP_XOR:  dec_alu_func = ALU_XOR;
          OP_SLT:  dec_alu_func = ALU_SLT;
          default: dec_alu_func = ALU_ADD;
        endcase
      end
      OP_ADDI: begin
        dec_wr      = 1'b1;
        dec_use_imm = 1'b1;
      end
      OP_LD: begin
        dec_wr      = 1'b1;
        dec_rd_mem  = 1'b1;
        dec_use_imm = 1'b1;
      end
      OP_ST: begin
        dec_wr_mem  = 1'b1;
        dec_use_imm = 1'b1;
        use_rb      = 1'b1;   // Store data
      end
      OP_BEQ: begin
        dec_beq = 1'b1;
        use_rb  = 1'b1;
      end
      OP_BNE: begin
        dec_bne = 1'b1;
        use_rb  = 1'b1;
      end
      OP_HALT: begin
        dec_halt = 1'b1;
        use_ra   = 1'b0;
      end
      default: begin
        dec_illegal = 1'b1;
        use_ra      = 1'b0;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // Hazard detection
  //////////////////////////////////////////////////

  // Source still owed by an older instruction in EX or MEM
  function automatic logic pending(input logic [REG_IDX_W-1:0] idx);
    return idx != '0 && ((id_ex_wr && id_ex_dest == idx) ||
                         (ex_mem_wr && ex_mem_dest == idx));
  endfunction

  always_comb begin
    id_stall = if_id_valid && ((use_ra && pending(ra)) || (use_rb && pending(rb)));
  end

  //////////////////////////////////////////////////
  // ID/EX register
  //////////////////////////////////////////////////
  always_ff @(posedge clock) begin
    if (reset || id_stall || ex_mem_take_branch || !if_id_valid) begin
      id_ex_valid   <= 1'b0;   // Bubble
      id_ex_wr      <= 1'b0;
      id_ex_rd_mem  <= 1'b0;
      id_ex_wr_mem  <= 1'b0;
      id_ex_beq     <= 1'b0;
      id_ex_bne     <= 1'b0;
      id_ex_halt    <= 1'b0;
      id_ex_illegal <= 1'b0;
    end else begin
      id_ex_valid   <= 1'b1;
      id_ex_wr      <= dec_wr;
      id_ex_rd_mem  <= dec_rd_mem;
      id_ex_wr_mem  <= dec_wr_mem;
      id_ex_beq     <= dec_beq;
      id_ex_bne     <= dec_bne;
      id_ex_halt    <= dec_halt;
      id_ex_illegal <= dec_illegal;
    end
  end

  always_ff @(posedge clock) begin
    id_ex_pc       <= if_id_pc;
    id_ex_rega     <= rega;
    id_ex_regb     <= regb;
    id_ex_imm      <= imm;
    id_ex_alu_func <= dec_alu_func;
    id_ex_use_imm  <= dec_use_imm;
    id_ex_dest     <= rd;
  end

endmodule

// ==== fetch_stage.sv ====
//////////////////////////////////////////////////
// Fetch and IF/ID register
//////////////////////////////////////////////////

`timescale 1ns/1ps

module fetch_stage
  import pipe_pkg::*;
(
  input  logic              clock,
  input  logic              reset,
  input  logic [XLEN-1:0]   mem_rdata,
  input  logic              mem_busy,           // Port taken by a data access
  input  logic              id_stall,
  input  logic              ex_mem_take_branch,
  input  logic [ADDR_W-1:0] ex_mem_target,
  output logic [ADDR_W-1:0] fetch_addr,
  output logic [ADDR_W-1:0] if_id_pc,
  output logic [XLEN-1:0]   if_id_inst,
  output logic              if_id_valid
);

  logic [ADDR_W-1:0] pc;

  assign fetch_addr = pc;

  // Redirect beats hold, hold beats increment
  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= '0;
    end else if (ex_mem_take_branch) begin
      pc <= ex_mem_target;
    end else if (!(id_stall || mem_busy)) begin
      pc <= pc + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // IF/ID register
  //////////////////////////////////////////////////
  always_ff @(posedge clock) begin
    if (reset || ex_mem_take_branch) begin
      if_id_valid <= 1'b0;
      if_id_inst  <= NOOP_INST;
    end else if (!id_stall) begin
      if_id_valid <= !mem_busy;                        // No word came back
      if_id_inst  <= mem_busy ? NOOP_INST : mem_rdata;
    end
  end

  always_ff @(posedge clock) begin
    if (!id_stall) if_id_pc <= pc;
  end

  // Stalled word came from pc - 1, so pc has stayed put since
  a_pc_hold_on_stall: assert property (@(posedge clock) disable iff (reset)
    id_stall && !ex_mem_take_branch |-> pc == if_id_pc + 1'b1);

endmodule

// ==== reg_file.sv ====
//////////////////////////////////////////////////
// Register file
//////////////////////////////////////////////////

`timescale 1ns/1ps

module reg_file
  import pipe_pkg::*;
(
  input  logic                 clock,
  input  logic                 reset,
  input  logic [REG_IDX_W-1:0] rd_idx_a,
  input  logic [REG_IDX_W-1:0] rd_idx_b,
  output logic [XLEN-1:0]      rd_data_a,
  output logic [XLEN-1:0]      rd_data_b,
  input  logic                 wr_en,
  input  logic [REG_IDX_W-1:0] wr_idx,
  input  logic [XLEN-1:0]      wr_data
);

  logic [XLEN-1:0] regs [1:NUM_REGS-1];   // r0 has no storage

  function automatic logic [XLEN-1:0] read_port(input logic [REG_IDX_W-1:0] idx);
    if (idx == '0) return '0;
    if (wr_en && wr_idx == idx) return wr_data;   // Write-through to decode
    return regs[idx];
  endfunction

  always_comb begin
    rd_data_a = read_port(rd_idx_a);
    rd_data_b = read_port(rd_idx_b);
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 1; i < NUM_REGS; i++) regs[i] <= '0;
    end else if (wr_en && wr_idx != '0) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // Writeback filters out r0 before it gets here
  a_no_r0_write: assert property (@(posedge clock) disable iff (reset)
    wr_en |-> wr_idx != '0);

endmodule

// ==== pipe_pkg.sv ====
//////////////////////////////////////////////////
// Teaching pipeline shared definitions
//////////////////////////////////////////////////

package pipe_pkg;

  localparam int XLEN      = 32;   // Data and instruction width
  localparam int ADDR_W    = 10;   // Word address, 1024 words
  localparam int REG_IDX_W = 4;
  localparam int NUM_REGS  = 16;
  localparam int IMM_W     = 16;

  //////////////////////////////////////////////////
  // Instruction format
  //   [31:28] opcode  [27:24] rd  [23:20] ra
  //   [19:16] rb      [15:0]  signed immediate
  // LD  rd <- mem[ra + imm]
  // ST  mem[ra + imm] <- rb
  // BEQ/BNE compare ra with rb, target pc + 1 + imm
  //////////////////////////////////////////////////

  typedef enum logic [3:0] {
    OP_ADD  = 4'h0,
    OP_SUB  = 4'h1,
    OP_AND  = 4'h2,
    OP_OR   = 4'h3,
    OP_XOR  = 4'h4,
    OP_SLT  = 4'h5,   // Signed compare
    OP_ADDI = 4'h6,
    OP_LD   = 4'h7,
    OP_ST   = 4'h8,
    OP_BEQ  = 4'h9,
    OP_BNE  = 4'ha,
    OP_HALT = 4'hb    // 4'hc..4'hf illegal
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD = 3'h0,
    ALU_SUB = 3'h1,
    ALU_AND = 3'h2,
    ALU_OR  = 3'h3,
    ALU_XOR = 3'h4,
    ALU_SLT = 3'h5
  } alu_func_e;

  // Memory port command
  typedef enum logic [1:0] {
    BUS_NONE  = 2'h0,
    BUS_LOAD  = 2'h1,
    BUS_STORE = 2'h2
  } bus_cmd_e;

  typedef enum logic [1:0] {
    NO_ERROR          = 2'h0,
    HALTED_ON_HALT    = 2'h1,
    HALTED_ON_ILLEGAL = 2'h2
  } error_e;

  // ADD r0, r0, r0 for bubbles
  localparam logic [XLEN-1:0] NOOP_INST = {OP_ADD, 4'd0, 4'd0, 4'd0, 16'd0};

endpackage
